/* tb.f */
source/ex_pkg.sv
source/ex_decode.sv
source/ex_alu.sv
source/ex_result.sv
source/ex_top.sv
bench/ex_properties.sv
bench/ex_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     = --timing --assert
TOP       = ex_tb
FILELIST  = tb.f
OBJDIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

# the run fails unless the pass line shows up in the output
sim: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJDIR)

/* bench/ex_tb.sv */
// testbench for the execute stage with a directed table followed by random items
// checks every result in order against a reference model of the instruction rules
`timescale 1ns/100ps

module ex_tb import ex_pkg::*; ();

    localparam int NROWS = 15;
    localparam int NRAND = 200;

    typedef struct packed {
        word_t     result;
        reg_idx_t  dest;
        logic      ovf;
        word_t     addr;
        mem_type_t mtype;
        mem_size_t msize;
        logic      msgn;
    } exp_t;

    typedef struct {
        ex_op_t   op;
        word_t    rs;
        word_t    rt;
        imm_t     imm;
        shamt_t   sh;
        reg_idx_t rti;
        reg_idx_t rdi;
        exp_t     e;
    } row_t;

    logic      clk;
    logic      rst_i;
    logic      in_valid_i;
    logic      in_ready_o;
    ex_op_t    op_i;
    word_t     rs_val_i;
    word_t     rt_val_i;
    imm_t      imm_i;
    shamt_t    shamt_i;
    reg_idx_t  rt_i;
    reg_idx_t  rd_i;
    logic      out_valid_o;
    logic      out_ready_i;
    word_t     result_o;
    reg_idx_t  dest_o;
    logic      overflow_o;
    word_t     mem_addr_o;
    mem_type_t mem_type_o;
    mem_size_t mem_size_o;
    logic      mem_signed_o;

    row_t   rows [NROWS];
    exp_t   exp_q [$];
    int     acc_q [$];
    int     cyc;
    int     errors;
    int     checks;
    logic   rand_phase;
    logic   lat_check;
    integer seed;
    integer bp_seed;

    ex_top u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        out_ready_i <= rand_phase ? 1'($random(bp_seed)) : 1'b1;
    end

    // leading bits equal to ones, up to 32 when the whole word matches
    function automatic word_t count_lead(input word_t v, input logic ones);
        int n;
        n = 0;
        while (n < 32 && v[31 - n] == ones)
        begin
            n++;
        end
        return word_t'(n);
    endfunction

    function automatic exp_t ref_model(input ex_op_t op, input word_t rs, input word_t rt,
                                       input imm_t imm, input shamt_t sh,
                                       input reg_idx_t rti, input reg_idx_t rdi);
        exp_t   e;
        word_t  se;
        word_t  ze;
        longint wide;
        se = {{16{imm[15]}}, imm};
        ze = {16'h0000, imm};
        e = '{result: '0, dest: rdi, ovf: 1'b0, addr: '0, mtype: MEM_R2R,
              msize: MEM_WORD, msgn: 1'b1};
        wide = 0;
        case (op)
            OP_ADD, OP_ADDU: e.result = rs + rt;
            OP_SUB, OP_SUBU: e.result = rs - rt;
            OP_SLT:  e.result = {31'd0, $signed(rs) < $signed(rt)};
            OP_SLTU: e.result = {31'd0, rs < rt};
            OP_AND:  e.result = rs & rt;
            OP_OR:   e.result = rs | rt;
            OP_XOR:  e.result = rs ^ rt;
            OP_NOR:  e.result = ~(rs | rt);
            OP_SLL:  e.result = rt << sh;
            OP_SRL:  e.result = rt >> sh;
            OP_SRA:  e.result = word_t'($signed(rt) >>> sh);
            OP_SLLV: e.result = rt << rs[4:0];
            OP_SRLV: e.result = rt >> rs[4:0];
            OP_SRAV: e.result = word_t'($signed(rt) >>> rs[4:0]);
            OP_CLZ:  e.result = count_lead(rs, 1'b0);
            OP_CLO:  e.result = count_lead(rs, 1'b1);
            OP_MOVZ, OP_MOVN:
            begin
                e.result = rs;
                if ((op == OP_MOVZ) != (rt == '0))
                begin
                    e.dest = '0;
                end
            end
            OP_NOP: e.dest = '0;
            default:
            begin
                // immediate, logic immediate and memory forms all write rt
                e.dest = rti;
                case (op)
                    OP_ADDI, OP_ADDIU: e.result = rs + se;
                    OP_SLTI:  e.result = {31'd0, $signed(rs) < $signed(se)};
                    OP_SLTIU: e.result = {31'd0, rs < se};
                    OP_ANDI:  e.result = rs & ze;
                    OP_ORI:   e.result = rs | ze;
                    OP_XORI:  e.result = rs ^ ze;
                    OP_LUI:   e.result = {imm, 16'h0000};
                    default:
                    begin
                        e.result = rt;
                        e.addr   = rs + se;
                        e.mtype  = (op >= OP_SB) ? MEM_R2M : MEM_M2R;
                        if (op >= OP_SB)
                        begin
                            e.dest = '0;
                        end
                        e.msgn = !(op == OP_LBU || op == OP_LHU);
                        if (op == OP_LB || op == OP_LBU || op == OP_SB)
                            e.msize = MEM_BYTE;
                        else if (op == OP_LH || op == OP_LHU || op == OP_SH)
                            e.msize = MEM_HALF;
                        else if (op == OP_LWL || op == OP_SWL)
                            e.msize = MEM_LEFT_WORD;
                        else if (op == OP_LWR || op == OP_SWR)
                            e.msize = MEM_RIGHT_WORD;
                    end
                endcase
            end
        endcase
        // only the trapping adds and subtracts flag signed overflow
        if (op == OP_ADD || op == OP_ADDI)
            wide = longint'($signed(rs)) + longint'($signed(op == OP_ADDI ? se : rt));
        else if (op == OP_SUB)
            wide = longint'($signed(rs)) - longint'($signed(rt));
        if (wide > 64'sh7fffffff || wide < -64'sh80000000)
        begin
            e.ovf  = 1'b1;
            e.dest = '0;
        end
        return e;
    endfunction

    task automatic set_row(input int i, input ex_op_t op, input word_t rs, input word_t rt,
                           input imm_t imm, input shamt_t sh, input word_t res,
                           input reg_idx_t dst, input logic ovf, input word_t addr,
                           input mem_type_t mt, input mem_size_t ms, input logic sg);
        rows[i] = '{op: op, rs: rs, rt: rt, imm: imm, sh: sh, rti: 5'd2, rdi: 5'd3,
                    e: '{result: res, dest: dst, ovf: ovf, addr: addr, mtype: mt,
                         msize: ms, msgn: sg}};
    endtask

    task automatic fill_table();
        set_row(0,  OP_ADD,   32'h7fffffff, 32'h1, 16'h0, 5'd0, 32'h80000000, 5'd0, 1'b1,
                32'h0, MEM_R2R, MEM_WORD, 1'b1);
        set_row(1,  OP_ADDU,  32'h7fffffff, 32'h1, 16'h0, 5'd0, 32'h80000000, 5'd3, 1'b0,
                32'h0, MEM_R2R, MEM_WORD, 1'b1);
        set_row(2,  OP_SUB,   32'h5, 32'h7, 16'h0, 5'd0, 32'hfffffffe, 5'd3, 1'b0,
                32'h0, MEM_R2R, MEM_WORD, 1'b1);
        set_row(3,  OP_ADDI,  32'h10, 32'h0, 16'hffff, 5'd0, 32'h0000000f, 5'd2, 1'b0,
                32'h0, MEM_R2R, MEM_WORD, 1'b1);
        set_row(4,  OP_SLTI,  32'hffffffff, 32'h0, 16'h0001, 5'd0, 32'h1, 5'd2, 1'b0,
                32'h0, MEM_R2R, MEM_WORD, 1'b1);
        set_row(5,  OP_SLTIU, 32'h5, 32'h0, 16'hffff, 5'd0, 32'h1, 5'd2, 1'b0,
                32'h0, MEM_R2R, MEM_WORD, 1'b1);
        // overlapping bit 15 tells or from xor
        set_row(6,  OP_ORI,   32'hf0f08000, 32'h0, 16'h8001, 5'd0, 32'hf0f08001, 5'd2, 1'b0,
                32'h0, MEM_R2R, MEM_WORD, 1'b1);
        set_row(7,  OP_LUI,   32'h0, 32'h0, 16'h1234, 5'd0, 32'h12340000, 5'd2, 1'b0,
                32'h0, MEM_R2R, MEM_WORD, 1'b1);
        set_row(8,  OP_SRAV,  32'h4, 32'h80000000, 16'h0, 5'd0, 32'hf8000000, 5'd3, 1'b0,
                32'h0, MEM_R2R, MEM_WORD, 1'b1);
        set_row(9,  OP_CLZ,   32'h0, 32'h0, 16'h0, 5'd0, 32'd32, 5'd3, 1'b0,
                32'h0, MEM_R2R, MEM_WORD, 1'b1);
        set_row(10, OP_CLO,   32'hffffffff, 32'h0, 16'h0, 5'd0, 32'd32, 5'd3, 1'b0,
                32'h0, MEM_R2R, MEM_WORD, 1'b1);
        set_row(11, OP_MOVZ,  32'haa, 32'h1, 16'h0, 5'd0, 32'haa, 5'd0, 1'b0,
                32'h0, MEM_R2R, MEM_WORD, 1'b1);
        set_row(12, OP_LBU,   32'h1000, 32'h55, 16'hfffc, 5'd0, 32'h55, 5'd2, 1'b0,
                32'h0ffc, MEM_M2R, MEM_BYTE, 1'b0);
        set_row(13, OP_SWL,   32'h2000, 32'h66, 16'h0010, 5'd0, 32'h66, 5'd0, 1'b0,
                32'h2010, MEM_R2M, MEM_LEFT_WORD, 1'b1);
        set_row(14, OP_NOP,   32'h1234, 32'h5678, 16'h0, 5'd0, 32'h0, 5'd0, 1'b0,
                32'h0, MEM_R2R, MEM_WORD, 1'b1);
    endtask

    // present one item and hold it until the accepting edge
    task automatic send(input row_t r);
        in_valid_i <= 1'b1;
        op_i       <= r.op;
        rs_val_i   <= r.rs;
        rt_val_i   <= r.rt;
        imm_i      <= r.imm;
        shamt_i    <= r.sh;
        rt_i       <= r.rti;
        rd_i       <= r.rdi;
        exp_q.push_back(r.e);
        forever
        begin
            @(negedge clk);
            if (in_ready_o)
                break;
            @(posedge clk);
        end
        @(posedge clk);
    endtask

    task automatic check_field(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // sample both handshakes half a cycle before the edge that completes them
    always @(negedge clk)
    begin
        exp_t e;
        int   acc;
        if (!rst_i && in_valid_i && in_ready_o)
            acc_q.push_back(cyc);
        if (!rst_i && out_valid_o && out_ready_i)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                errors++;
                $display("an output item arrived with no item pending at %0t", $time);
            end
            if (exp_q.size() != 0)
            begin
                e   = exp_q.pop_front();
                acc = acc_q.pop_front();
                check_field("result", result_o, e.result);
                check_field("dest", 32'(dest_o), 32'(e.dest));
                check_field("overflow", 32'(overflow_o), 32'(e.ovf));
                check_field("mem_addr", mem_addr_o, e.addr);
                check_field("mem_type", 32'(mem_type_o), 32'(e.mtype));
                check_field("mem_size", 32'(mem_size_o), 32'(e.msize));
                check_field("mem_signed", 32'(mem_signed_o), 32'(e.msgn));
                if (lat_check)
                    check_field("latency", 32'(cyc - acc), 32'd2);
            end
        end
    end

    initial
    begin
        repeat ((NROWS + NRAND) * 10) @(posedge clk);
        $display("watchdog expired with %0d items still pending", exp_q.size());
        $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        row_t r;
        seed        = 32'hd954;
        bp_seed     = 32'hd954 + 1;
        cyc         = 0;
        errors      = 0;
        checks      = 0;
        rand_phase  = 1'b0;
        lat_check   = 1'b1;
        rst_i       = 1'b1;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b1;
        op_i        = OP_NOP;
        rs_val_i    = '0;
        rt_val_i    = '0;
        imm_i       = '0;
        shamt_i     = '0;
        rt_i        = '0;
        rd_i        = '0;
        fill_table();
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        for (int i = 0; i < NROWS; i++)
            send(rows[i]);
        in_valid_i <= 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk);
        @(posedge clk);
        lat_check  = 1'b0;
        rand_phase = 1'b1;
        for (int i = 0; i < NRAND; i++)
        begin
            r.op  = ex_op_t'(8'($unsigned($random(seed)) % 41));
            r.rs  = $random(seed);
            r.rt  = (($random(seed) & 3) == 0) ? '0 : $random(seed);
            r.imm = 16'($random(seed));
            r.sh  = 5'($random(seed));
            r.rti = 5'($random(seed));
            r.rdi = 5'($random(seed));
            r.e   = ref_model(r.op, r.rs, r.rt, r.imm, r.sh, r.rti, r.rdi);
            send(r);
        end
        in_valid_i <= 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* bench/ex_properties.sv */
// handshake assertions bound into the execute stage top
`timescale 1ns/100ps

module ex_properties import ex_pkg::*; (
    input logic      clk,
    input logic      rst_i,
    input logic      out_valid_o,
    input logic      out_ready_i,
    input word_t     result_o,
    input reg_idx_t  dest_o,
    input logic      overflow_o,
    input word_t     mem_addr_o,
    input mem_type_t mem_type_o,
    input mem_size_t mem_size_o,
    input logic      mem_signed_o
);

    // stalled output must not change
    assert property (@(posedge clk) disable iff (rst_i)
        out_valid_o && !out_ready_i |=> $stable({result_o, dest_o, overflow_o, mem_addr_o,
                                                 mem_type_o, mem_size_o, mem_signed_o}))
    else $error("output data changed while stalled");

    assert property (@(posedge clk) rst_i |=> !out_valid_o)
    else $error("out_valid_o high after reset");

    // a stalled result stays valid until the consumer takes it
    assert property (@(posedge clk) disable iff (rst_i)
        out_valid_o && !out_ready_i |=> out_valid_o)
    else $error("out_valid_o dropped while stalled");

endmodule

bind ex_top ex_properties u_props (.*);

/* source/ex_top.sv */
// top of the execute stage, decode register, alu and result register
`timescale 1ns/100ps

module ex_top import ex_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      in_valid_i,
    output logic      in_ready_o,
    input  ex_op_t    op_i,
    input  word_t     rs_val_i,
    input  word_t     rt_val_i,
    input  imm_t      imm_i,
    input  shamt_t    shamt_i,
    input  reg_idx_t  rt_i,
    input  reg_idx_t  rd_i,
    output logic      out_valid_o,
    input  logic      out_ready_i,
    output word_t     result_o,
    output reg_idx_t  dest_o,
    output logic      overflow_o,
    output word_t     mem_addr_o,
    output mem_type_t mem_type_o,
    output mem_size_t mem_size_o,
    output logic      mem_signed_o
);

    logic      dec_valid;
    alu_fn_t   dec_fn;
    word_t     dec_a;
    word_t     dec_b;
    shamt_t    dec_shamt;
    reg_idx_t  dec_dest;
    logic      dec_mov_z;
    logic      dec_mov_nz;
    mem_type_t dec_mem_type;
    mem_size_t dec_mem_size;
    logic      dec_mem_signed;
    word_t     dec_store_data;
    word_t     alu_result;
    reg_idx_t  alu_dest;
    logic      alu_overflow;
    word_t     alu_mem_addr;
    logic      res_ready;

    ex_decode u_decode (
        .clk              (clk),
        .rst_i            (rst_i),
        .in_valid_i       (in_valid_i),
        .op_i             (op_i),
        .rs_val_i         (rs_val_i),
        .rt_val_i         (rt_val_i),
        .imm_i            (imm_i),
        .shamt_i          (shamt_i),
        .rt_i             (rt_i),
        .rd_i             (rd_i),
        .ready_i          (res_ready),
        .in_ready_o       (in_ready_o),
        .valid_o          (dec_valid),
        .fn_o             (dec_fn),
        .a_o              (dec_a),
        .b_o              (dec_b),
        .shamt_o          (dec_shamt),
        .dest_o           (dec_dest),
        .mov_on_zero_o    (dec_mov_z),
        .mov_on_nonzero_o (dec_mov_nz),
        .mem_type_o       (dec_mem_type),
        .mem_size_o       (dec_mem_size),
        .mem_signed_o     (dec_mem_signed),
        .store_data_o     (dec_store_data)
    );

    ex_alu u_alu (
        .fn_i             (dec_fn),
        .a_i              (dec_a),
        .b_i              (dec_b),
        .shamt_i          (dec_shamt),
        .dest_i           (dec_dest),
        .mov_on_zero_i    (dec_mov_z),
        .mov_on_nonzero_i (dec_mov_nz),
        .mem_type_i       (dec_mem_type),
        .store_data_i     (dec_store_data),
        .result_o         (alu_result),
        .dest_o           (alu_dest),
        .overflow_o       (alu_overflow),
        .mem_addr_o       (alu_mem_addr)
    );

    // alu is combinational, so the decode valid qualifies its outputs
    ex_result u_result (
        .clk          (clk),
        .rst_i        (rst_i),
        .valid_i      (dec_valid),
        .result_i     (alu_result),
        .dest_i       (alu_dest),
        .overflow_i   (alu_overflow),
        .mem_addr_i   (alu_mem_addr),
        .mem_type_i   (dec_mem_type),
        .mem_size_i   (dec_mem_size),
        .mem_signed_i (dec_mem_signed),
        .out_ready_i  (out_ready_i),
        .ready_o      (res_ready),
        .out_valid_o  (out_valid_o),
        .result_o     (result_o),
        .dest_o       (dest_o),
        .overflow_o   (overflow_o),
        .mem_addr_o   (mem_addr_o),
        .mem_type_o   (mem_type_o),
        .mem_size_o   (mem_size_o),
        .mem_signed_o (mem_signed_o)
    );

endmodule

/* source/ex_result.sv */
// output stage register, holds a result until the consumer takes it
`timescale 1ns/100ps

module ex_result import ex_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      valid_i,
    input  word_t     result_i,
    input  reg_idx_t  dest_i,
    input  logic      overflow_i,
    input  word_t     mem_addr_i,
    input  mem_type_t mem_type_i,
    input  mem_size_t mem_size_i,
    input  logic      mem_signed_i,
    input  logic      out_ready_i,
    output logic      ready_o,
    output logic      out_valid_o,
    output word_t     result_o,
    output reg_idx_t  dest_o,
    output logic      overflow_o,
    output word_t     mem_addr_o,
    output mem_type_t mem_type_o,
    output mem_size_t mem_size_o,
    output logic      mem_signed_o
);

    assign ready_o = !out_valid_o || out_ready_i;

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            out_valid_o <= 1'b0;
        end
        else if (ready_o)
        begin
            out_valid_o <= valid_i;
        end
    end

    // data only moves on a load, so it holds under back-pressure
    always_ff @(posedge clk)
    begin
        if (valid_i && ready_o)
        begin
            result_o     <= result_i;
            dest_o       <= dest_i;
            overflow_o   <= overflow_i;
            mem_addr_o   <= mem_addr_i;
            mem_type_o   <= mem_type_i;
            mem_size_o   <= mem_size_i;
            mem_signed_o <= mem_signed_i;
        end
    end

endmodule

/* source/ex_alu.sv */
// combinational datapath of the execute stage
// one shared adder for add, sub, compares and address generation
`timescale 1ns/100ps

module ex_alu import ex_pkg::*; (
    input  alu_fn_t   fn_i,
    input  word_t     a_i,
    input  word_t     b_i,
    input  shamt_t    shamt_i,
    input  reg_idx_t  dest_i,
    input  logic      mov_on_zero_i,
    input  logic      mov_on_nonzero_i,
    input  mem_type_t mem_type_i,
    input  word_t     store_data_i,
    output word_t     result_o,
    output reg_idx_t  dest_o,
    output logic      overflow_o,
    output word_t     mem_addr_o
);

    logic  sub_en;
    word_t b_op;
    word_t sum;
    logic  carry;
    logic  ovf_raw;
    logic  trap_fn;
    logic  lt_signed;
    logic  lt_unsigned;
    logic  mov_skip;

    // number of leading zeros, 32 when v is zero
    function automatic logic [5:0] lead_zeros(input word_t v);
        logic [5:0] cnt;
        logic       found;
        cnt   = 6'd0;
        found = 1'b0;
        for (int i = 31; i >= 0; i--)
        begin
            if (v[i])
            begin
                found = 1'b1;
            end
            else if (!found)
            begin
                cnt = cnt + 6'd1;
            end
        end
        return cnt;
    endfunction

    assign sub_en = (fn_i == FN_SUB) || (fn_i == FN_SUBU) ||
                    (fn_i == FN_SLT) || (fn_i == FN_SLTU);

    // subtract as a + ~b + 1
    assign b_op         = sub_en ? ~b_i : b_i;
    assign {carry, sum} = {1'b0, a_i} + {1'b0, b_op} + {32'd0, sub_en};

    // same sign in, other sign out
    assign ovf_raw = (a_i[31] == b_op[31]) && (sum[31] != a_i[31]);
    assign trap_fn = (fn_i == FN_ADD) || (fn_i == FN_SUB);

    assign lt_signed   = (a_i[31] != b_i[31]) ? a_i[31] : sum[31];
    assign lt_unsigned = !carry;

    always_comb
    begin
        case (fn_i)
            FN_ADD, FN_ADDU, FN_SUB, FN_SUBU: result_o = sum;
            FN_SLT:    result_o = {31'd0, lt_signed};
            FN_SLTU:   result_o = {31'd0, lt_unsigned};
            FN_AND:    result_o = a_i & b_i;
            FN_OR:     result_o = a_i | b_i;
            FN_XOR:    result_o = a_i ^ b_i;
            FN_NOR:    result_o = ~(a_i | b_i);
            FN_LUI:    result_o = {a_i[15:0], 16'h0000};
            FN_SLL:    result_o = b_i << shamt_i;
            FN_SRL:    result_o = b_i >> shamt_i;
            FN_SRA:    result_o = word_t'($signed(b_i) >>> shamt_i);
            FN_CLZ:    result_o = {26'd0, lead_zeros(a_i)};
            FN_CLO:    result_o = {26'd0, lead_zeros(~a_i)};
            FN_PASS_S: result_o = a_i;
            FN_PASS_T: result_o = store_data_i;
            default:   result_o = '0;
        endcase
    end

    assign overflow_o = trap_fn && ovf_raw;

    // conditional move drops its write when rt fails the test
    assign mov_skip = (mov_on_zero_i && (b_i != '0)) ||
                      (mov_on_nonzero_i && (b_i == '0));

    assign dest_o = (overflow_o || mov_skip) ? '0 : dest_i;

    assign mem_addr_o = (mem_type_i == MEM_R2R) ? '0 : sum;

endmodule

/* source/ex_decode.sv */
// input stage register of the execute stage
// decodes the opcode into a datapath function, operands and destination
`timescale 1ns/100ps

module ex_decode import ex_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      in_valid_i,
    input  ex_op_t    op_i,
    input  word_t     rs_val_i,
    input  word_t     rt_val_i,
    input  imm_t      imm_i,
    input  shamt_t    shamt_i,
    input  reg_idx_t  rt_i,
    input  reg_idx_t  rd_i,
    input  logic      ready_i,
    output logic      in_ready_o,
    output logic      valid_o,
    output alu_fn_t   fn_o,
    output word_t     a_o,
    output word_t     b_o,
    output shamt_t    shamt_o,
    output reg_idx_t  dest_o,
    output logic      mov_on_zero_o,
    output logic      mov_on_nonzero_o,
    output mem_type_t mem_type_o,
    output mem_size_t mem_size_o,
    output logic      mem_signed_o,
    output word_t     store_data_o
);

    word_t     sext_imm;
    word_t     zext_imm;
    alu_fn_t   fn_d;
    word_t     a_d;
    word_t     b_d;
    shamt_t    shamt_d;
    reg_idx_t  dest_d;
    logic      movz_d;
    logic      movn_d;
    mem_type_t mem_type_d;
    mem_size_t mem_size_d;
    logic      mem_signed_d;
    logic      accept;

    assign sext_imm = {{16{imm_i[15]}}, imm_i};
    assign zext_imm = {16'h0000, imm_i};

    // empty, or our item leaves this cycle
    assign in_ready_o = !valid_o || ready_i;
    assign accept     = in_valid_i && in_ready_o;

    always_comb
    begin
        fn_d       = FN_ADDU;
        a_d        = rs_val_i;
        b_d        = rt_val_i;
        shamt_d    = shamt_i;
        dest_d     = rd_i;
        movz_d     = 1'b0;
        movn_d     = 1'b0;
        mem_type_d = MEM_R2R;
        case (op_i)
            OP_ADD:   fn_d = FN_ADD;
            OP_ADDU:  fn_d = FN_ADDU;
            OP_SUB:   fn_d = FN_SUB;
            OP_SUBU:  fn_d = FN_SUBU;
            OP_SLT:   fn_d = FN_SLT;
            OP_SLTU:  fn_d = FN_SLTU;
            OP_AND:   fn_d = FN_AND;
            OP_OR:    fn_d = FN_OR;
            OP_XOR:   fn_d = FN_XOR;
            OP_NOR:   fn_d = FN_NOR;
            OP_SLL:   fn_d = FN_SLL;
            OP_SRL:   fn_d = FN_SRL;
            OP_SRA:   fn_d = FN_SRA;
            OP_CLZ:   fn_d = FN_CLZ;
            OP_CLO:   fn_d = FN_CLO;
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU:
            begin
                b_d    = sext_imm;
                dest_d = rt_i;
                fn_d   = (op_i == OP_ADDI)  ? FN_ADD :
                         (op_i == OP_ADDIU) ? FN_ADDU :
                         (op_i == OP_SLTI)  ? FN_SLT : FN_SLTU;
            end
            // logic immediates are zero extended
            OP_ANDI, OP_ORI, OP_XORI:
            begin
                b_d    = zext_imm;
                dest_d = rt_i;
                fn_d   = (op_i == OP_ANDI) ? FN_AND :
                         (op_i == OP_ORI)  ? FN_OR : FN_XOR;
            end
            OP_LUI:
            begin
                fn_d   = FN_LUI;
                a_d    = zext_imm;
                dest_d = rt_i;
            end
            OP_SLLV, OP_SRLV, OP_SRAV:
            begin
                shamt_d = rs_val_i[4:0];
                fn_d    = (op_i == OP_SLLV) ? FN_SLL :
                          (op_i == OP_SRLV) ? FN_SRL : FN_SRA;
            end
            // rt value stays on b for the condition check
            OP_MOVZ, OP_MOVN:
            begin
                fn_d   = FN_PASS_S;
                movz_d = (op_i == OP_MOVZ);
                movn_d = (op_i == OP_MOVN);
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR:
            begin
                fn_d       = FN_PASS_T;
                b_d        = sext_imm;
                dest_d     = rt_i;
                mem_type_d = MEM_M2R;
            end
            OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR:
            begin
                fn_d       = FN_PASS_T;
                b_d        = sext_imm;
                dest_d     = '0;
                mem_type_d = MEM_R2M;
            end
            // nop writes nothing and gives zero
            default:
            begin
                fn_d   = FN_AND;
                b_d    = '0;
                dest_d = '0;
            end
        endcase
    end

    always_comb
    begin
        case (op_i)
            OP_LB, OP_LBU, OP_SB: mem_size_d = MEM_BYTE;
            OP_LH, OP_LHU, OP_SH: mem_size_d = MEM_HALF;
            OP_LWL, OP_SWL:       mem_size_d = MEM_LEFT_WORD;
            OP_LWR, OP_SWR:       mem_size_d = MEM_RIGHT_WORD;
            default:              mem_size_d = MEM_WORD;
        endcase
    end

    assign mem_signed_d = !(op_i == OP_LBU || op_i == OP_LHU);

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            valid_o <= 1'b0;
        end
        else if (in_ready_o)
        begin
            valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            fn_o             <= fn_d;
            a_o              <= a_d;
            b_o              <= b_d;
            shamt_o          <= shamt_d;
            dest_o           <= dest_d;
            mov_on_zero_o    <= movz_d;
            mov_on_nonzero_o <= movn_d;
            mem_type_o       <= mem_type_d;
            mem_size_o       <= mem_size_d;
            mem_signed_o     <= mem_signed_d;
            store_data_o     <= rt_val_i;
        end
    end

endmodule

/* source/ex_pkg.sv */
// shared types and encodings for the integer execute stage
// imported by every stage module and by the testbench
package ex_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [15:0] imm_t;
    typedef logic [4:0]  shamt_t;

    // instructions kept by this stage, OP_NOP first
    typedef enum logic [7:0] {
        OP_NOP,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_ADDI, OP_ADDIU,
        OP_SLT, OP_SLTU, OP_SLTI, OP_SLTIU,
        OP_AND, OP_OR, OP_XOR, OP_NOR, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_CLZ, OP_CLO,
        OP_MOVZ, OP_MOVN,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR,
        OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR
    } ex_op_t;

    // access direction seen by the memory stage
    typedef enum logic [1:0] {
        MEM_R2R = 2'd0,
        MEM_M2R = 2'd1,
        MEM_R2M = 2'd2
    } mem_type_t;

    typedef enum logic [2:0] {
        MEM_BYTE       = 3'd0,
        MEM_HALF       = 3'd1,
        MEM_WORD       = 3'd2,
        MEM_LEFT_WORD  = 3'd3,
        MEM_RIGHT_WORD = 3'd4
    } mem_size_t;

    // datapath function picked by decode
    // 18 functions need a 5 bit code
    typedef enum logic [4:0] {
        FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
        FN_SLT, FN_SLTU,
        FN_AND, FN_OR, FN_XOR, FN_NOR, FN_LUI,
        FN_SLL, FN_SRL, FN_SRA,
        FN_CLZ, FN_CLO,
        FN_PASS_S, FN_PASS_T
    } alu_fn_t;

endpackage
